// File: icache.f
hdl/fsab_pkg.sv
hdl/fsab_req.sv
hdl/icache_tag_ctl.sv
hdl/icache_fill.sv
hdl/icache_data_ram.sv
hdl/icache.sv
bench/fsab_mem_model.sv
bench/icache_tb.sv

// File: bench/icache_tb.sv
/* Bench for the instruction cache.
 * Directed tests on the core port against the FSAB memory model; the bench
 * keeps its own tag table to predict hits and misses. One line per test,
 * then the totals.
 */

module icache_tb
	import fsab_pkg::*;
();

	logic        clk;
	logic        rst_b;
	logic        fsabi_clk;
	logic        fsabi_rst_b;
	logic [31:0] rd_addr;
	logic        rd_req;
	logic        rd_wait;
	logic [31:0] rd_data;
	logic        fsabo_credit;
	fsab_req_t   fsabo;
	fsab_resp_t  fsabi;
	logic        hold_credits;
	logic        inject_foreign;

	int          errors;
	int          checks;
	int          tests;
	int          req_count;	// requests seen on the bus.
	int          credit_count;	// credit pulses seen.
	int          seed;
	fsab_req_t   last_req;
	string       test_name;
	logic [21:0] tag_tbl [16];	// expected cache contents per index.
	logic        vld_tbl [16];

	always #5 clk = ~clk;
	always #7 fsabi_clk = ~fsabi_clk;

	icache #(
		.FSAB_CREDITS (2)
	) icache_inst (
		.clk          (clk),
		.rst_b        (rst_b),
		.rd_addr      (rd_addr),
		.rd_req       (rd_req),
		.rd_wait      (rd_wait),
		.rd_data      (rd_data),
		.fsabo        (fsabo),
		.fsabo_credit (fsabo_credit),
		.fsabi_clk    (fsabi_clk),
		.fsabi_rst_b  (fsabi_rst_b),
		.fsabi        (fsabi)
	);

	fsab_mem_model mem_inst (
		.clk            (clk),
		.fsabi_clk      (fsabi_clk),
		.fsabo          (fsabo),
		.hold_credits   (hold_credits),
		.inject_foreign (inject_foreign),
		.fsabo_credit   (fsabo_credit),
		.fsabi          (fsabi)
	);

	// bus monitor.
	always @(posedge clk) begin
		if (fsabo.valid) begin
			req_count = req_count + 1;
			last_req  = fsabo;
		end
		if (fsabo_credit) begin
			credit_count = credit_count + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_val(input string what, input logic [31:0] exp,
	                         input logic [31:0] got);
		checks = checks + 1;
		assert (got === exp) else begin
			$display("CHECK FAILED %s %s: expected %h, actual %h",
			         test_name, what, exp, got);
			errors = errors + 1;
		end
	endtask

	task automatic start_read(input logic [31:0] addr);
		@(posedge clk);
		#1;
		rd_addr = addr;
		rd_req  = 1'b1;
		@(negedge clk);	// rd_wait has settled.
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (rd_wait && n < 200) begin
			@(negedge clk);
			n = n + 1;
		end
		if (rd_wait) begin
			$display("timeout in %s: rd_wait still high after 200 cycles", test_name);
			errors = errors + 1;
		end
	endtask

	// word comes one cycle after rd_wait is seen low.
	task automatic end_read(input logic [31:0] addr);
		@(posedge clk);
		#1;
		rd_req = 1'b0;
		@(negedge clk);
		check_val("rd_data", ~{addr[31:2], 2'b00}, rd_data);
		tag_tbl[addr[9:6]] = addr[31:10];
		vld_tbl[addr[9:6]] = 1'b1;
	endtask

	task automatic fetch_check(input logic [31:0] addr);
		logic exp_miss;
		exp_miss = !vld_tbl[addr[9:6]] || (tag_tbl[addr[9:6]] != addr[31:10]);
		start_read(addr);
		check_val("rd_wait", 32'(exp_miss), 32'(rd_wait));
		wait_ready();
		end_read(addr);
	endtask

	task automatic check_line(input logic [31:0] base);
		for (int w = 0; w < 16; w++) begin
			fetch_check(base + 32'(4 * w));
		end
	endtask

	task automatic report(input int err0);
		tests = tests + 1;
		if (errors == err0) begin
			$display("%s: pass", test_name);
		end else begin
			$display("%s: %0d errors", test_name, errors - err0);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_request();
		int err0;
		int n0;
		err0      = errors;
		test_name = "reset_request";
		check_val("rd_wait idle", 0, 32'(rd_wait));
		check_val("fsabo.valid idle", 0, 32'(fsabo.valid));
		n0 = req_count;
		fetch_check(32'h0000_1048);
		check_val("requests", 1, 32'(req_count - n0));
		check_val("addr", 32'h0000_1040, last_req.addr);	// line base.
		check_val("mode", 32'(FSAB_READ), 32'(last_req.mode));
		check_val("len", 8, 32'(last_req.len));
		check_val("did", 32'(FSAB_DID_CPU), 32'(last_req.did));
		check_val("subdid", 32'(FSAB_SUBDID_CPU_ICACHE), 32'(last_req.subdid));
		check_val("data hi", 0, last_req.data[63:32]);	// reads carry no payload.
		check_val("data lo", 0, last_req.data[31:0]);
		check_val("mask", 0, 32'(last_req.mask));
		report(err0);
	endtask

	task automatic test_cold_miss();
		int err0;
		int n0;
		err0      = errors;
		test_name = "cold_miss";
		n0        = req_count;
		fetch_check(32'h0000_20c4);
		check_val("requests", 1, 32'(req_count - n0));
		report(err0);
	endtask

	task automatic test_line_hits();
		int err0;
		err0      = errors;
		test_name = "line_hits";
		check_line(32'h0000_20c0);	// filled by the cold miss.
		report(err0);
	endtask

	task automatic test_conflict();
		int err0;
		err0      = errors;
		test_name = "conflict";
		fetch_check(32'h0000_3140);	// index 5.
		fetch_check(32'h0000_3540);	// same index 5 with another tag.
		fetch_check(32'h0000_3140);	// the evicted line misses again.
		fetch_check(32'h0000_20c8);	// index 3 untouched.
		for (int i = 0; i < 30; i++) begin
			fetch_check(32'h0001_0000 | ($urandom & 32'h0000_1ffc));	// 8 KB window.
		end
		report(err0);
	endtask

	task automatic test_credit_hold();
		int err0;
		int n0;
		int n;
		err0      = errors;
		test_name = "credit_hold";
		n         = 0;
		while (req_count != credit_count && n < 200) begin
			@(negedge clk);
			n = n + 1;
		end
		if (req_count != credit_count) begin
			$display("timeout in %s: credits not returned after 200 cycles", test_name);
			errors = errors + 1;
		end
		@(posedge clk);
		#1;
		hold_credits = 1'b1;
		n0           = req_count;
		fetch_check(32'h0040_0000);	// spends both credits.
		fetch_check(32'h0040_0040);
		start_read(32'h0040_0080);
		for (n = 0; n < 40; n++) begin
			@(negedge clk);
		end
		check_val("rd_wait held", 1, 32'(rd_wait));
		check_val("requests held", 2, 32'(req_count - n0));
		@(posedge clk);
		#1;
		hold_credits = 1'b0;
		wait_ready();
		end_read(32'h0040_0080);
		check_val("requests", 3, 32'(req_count - n0));
		report(err0);
	endtask

	task automatic test_foreign_beats();
		int err0;
		err0      = errors;
		test_name = "foreign_beats";
		@(posedge clk);
		#1;
		inject_foreign = 1'b1;
		check_line(32'h0050_0380);	// cold line at index 14.
		@(posedge clk);
		#1;
		inject_foreign = 1'b0;
		report(err0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		fsabi_rst_b = 1'b0;
		repeat (3) @(posedge fsabi_clk);
		#1 fsabi_rst_b = 1'b1;
	end

	initial begin
		clk            = 1'b0;
		fsabi_clk      = 1'b0;
		rst_b          = 1'b0;
		rd_addr        = '0;
		rd_req         = 1'b0;
		hold_credits   = 1'b0;
		inject_foreign = 1'b0;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		req_count      = 0;
		credit_count   = 0;
		last_req       = '0;
		for (int i = 0; i < 16; i++) begin
			tag_tbl[i] = '0;
			vld_tbl[i] = 1'b0;	// cold cache.
		end
		seed = $urandom(41);
		repeat (3) @(posedge clk);
		#1 rst_b = 1'b1;
		repeat (3) @(posedge clk);	// bus side is out of reset too.

		test_reset_request();
		test_cold_miss();
		test_line_hits();
		test_conflict();
		test_credit_hold();
		test_foreign_beats();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: bench/fsab_mem_model.sv
/* FSAB memory model for the icache bench.
 * Answers each line read with eight beats, every 32-bit word holding the
 * complement of its byte address, and pays one credit back per request.
 * hold_credits keeps credits owed; inject_foreign slips a beat with another
 * subdid in front of every real beat.
 */

module fsab_mem_model
	import fsab_pkg::*;
(
	input  logic       clk,
	input  logic       fsabi_clk,
	input  fsab_req_t  fsabo,
	input  logic       hold_credits,	// credits stay owed while high.
	input  logic       inject_foreign,	// foreign beat before each real one.
	output logic       fsabo_credit,
	output fsab_resp_t fsabi
);

	localparam int CREDIT_DELAY = 3;	// clk cycles before a credit goes back.
	localparam int RESP_DELAY   = 4;	// fsabi_clk cycles before the first beat.

	logic [31:0] req_q [$];	// line bases accepted but not yet answered.
	int          owed;	// credits not yet returned.
	int          delay_cnt;
	logic        credit_next;
	logic [31:0] base;

	function automatic fsab_resp_t make_beat(input logic [3:0]  subdid,
	                                         input logic [63:0] data);
		fsab_resp_t b;
		b        = '0;
		b.valid  = 1'b1;
		b.did    = FSAB_DID_CPU;
		b.subdid = subdid;
		b.data   = data;
		return b;
	endfunction

	initial begin
		fsabo_credit = 1'b0;
		owed         = 0;
		delay_cnt    = 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// request side, on clk
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (fsabo.valid) begin
			req_q.push_back(fsabo.addr);
			owed = owed + 1;
		end
		credit_next = 1'b0;	// a pulse lasts one cycle.
		if (owed > 0 && !hold_credits) begin
			if (delay_cnt == CREDIT_DELAY) begin
				credit_next = 1'b1;
				owed        = owed - 1;
				delay_cnt   = 0;
			end else begin
				delay_cnt = delay_cnt + 1;
			end
		end
		fsabo_credit <= #1 credit_next;
	end

	////////////////////////////////////////////////////////////////////////////
	// response side, on fsabi_clk
	////////////////////////////////////////////////////////////////////////////

	initial begin
		fsabi = '0;
		forever begin
			@(posedge fsabi_clk);
			if (req_q.size() != 0) begin
				base = req_q.pop_front();
				repeat (RESP_DELAY) @(posedge fsabi_clk);	// lets the fill engine rewind.
				for (int k = 0; k < ICACHE_DWORDS; k++) begin
					if (inject_foreign) begin
						#1 fsabi = make_beat(4'h7, 64'hbad0_bad1_bad2_bad3);	// another client.
						@(posedge fsabi_clk);
					end
					// higher address goes in the high word.
					#1 fsabi = make_beat(FSAB_SUBDID_CPU_ICACHE,
					                     {~(base + 32'(8 * k + 4)), ~(base + 32'(8 * k))});
					@(posedge fsabi_clk);
				end
				#1 fsabi = '0;
			end
		end
	end

endmodule

// File: hdl/icache.sv
/* Instruction cache, 16 direct-mapped lines of 64 bytes.
 * The core side runs on clk with a request and wait level; misses go out
 * as line reads on the FSAB bus and come back on fsabi_clk.
 * FSAB_CREDITS is the number of bus credits granted at reset.
 */

module icache
	import fsab_pkg::*;
#(
	parameter int FSAB_CREDITS = 4
) (
	input  logic        clk,
	input  logic        rst_b,

	// core fetch port.
	input  logic [31:0] rd_addr,
	input  logic        rd_req,
	output logic        rd_wait,	// combinational, high on a miss.
	output logic [31:0] rd_data,	// one cycle after the address.

	// outbound bus.
	output fsab_req_t   fsabo,
	input  logic        fsabo_credit,

	// inbound bus, own clock domain.
	input  logic        fsabi_clk,
	input  logic        fsabi_rst_b,
	input  fsab_resp_t  fsabi
);

	icache_addr_u  rd_addr_u;	// same word, field view.
	logic [31:0]   fill_base;
	logic          credit_avail;
	logic          miss_start;
	icache_addr_u  fill_addr;
	logic          cur_read;	// clk to fsabi_clk toggle.
	logic          done_read;	// fsabi_clk to clk toggle.
	logic          wr_en;
	icache_dword_t wr_dword;
	logic [63:0]   wr_data;

	assign rd_addr_u.word = rd_addr;
	assign fill_base      = {rd_addr[31:6], 6'b0};	// line aligned.

	////////////////////////////////////////////////////////////////////////////
	// clk domain
	////////////////////////////////////////////////////////////////////////////

	fsab_req #(
		.FSAB_CREDITS (FSAB_CREDITS)
	) req_inst (
		.clk          (clk),
		.rst_b        (rst_b),
		.miss_start   (miss_start),
		.fill_base    (fill_base),
		.fsabo_credit (fsabo_credit),
		.credit_avail (credit_avail),
		.fsabo        (fsabo)
	);

	icache_tag_ctl tag_ctl_inst (
		.clk          (clk),
		.rst_b        (rst_b),
		.rd_addr      (rd_addr_u),
		.rd_req       (rd_req),
		.credit_avail (credit_avail),
		.done_read    (done_read),
		.rd_wait      (rd_wait),
		.miss_start   (miss_start),
		.fill_addr    (fill_addr),
		.cur_read     (cur_read)
	);

	////////////////////////////////////////////////////////////////////////////
	// fsabi_clk domain and the shared store
	////////////////////////////////////////////////////////////////////////////

	icache_fill fill_inst (
		.fsabi_clk   (fsabi_clk),
		.fsabi_rst_b (fsabi_rst_b),
		.fsabi       (fsabi),
		.cur_read    (cur_read),
		.wr_en       (wr_en),
		.wr_dword    (wr_dword),
		.wr_data     (wr_data),
		.done_read   (done_read)
	);

	// wr_idx comes straight from the frozen fill address.
	icache_data_ram data_ram_inst (
		.clk       (clk),
		.rd_addr   (rd_addr_u),
		.fsabi_clk (fsabi_clk),
		.wr_en     (wr_en),
		.wr_idx    (fill_addr.f.idx),
		.wr_dword  (wr_dword),
		.wr_data   (wr_data),
		.rd_data   (rd_data)
	);

endmodule

// File: hdl/icache_data_ram.sv
/* Data store of the instruction cache, 128 doublewords.
 * Kept as separate hi and lo word arrays, written a beat at a time on
 * fsabi_clk and read on clk with a registered output.
 */

module icache_data_ram
	import fsab_pkg::*;
(
	input  logic          clk,
	input  icache_addr_u  rd_addr,	// core address, read every cycle.
	input  logic          fsabi_clk,
	input  logic          wr_en,
	input  icache_idx_t   wr_idx,	// line being filled.
	input  icache_dword_t wr_dword,
	input  logic [63:0]   wr_data,
	output logic [31:0]   rd_data
);

	logic [31:0] mem_hi [ICACHE_LINES*ICACHE_DWORDS];	// addr bit 2 set.
	logic [31:0] mem_lo [ICACHE_LINES*ICACHE_DWORDS];	// addr bit 2 clear.

	logic [31:0] hi_q;
	logic [31:0] lo_q;
	logic        half_q;	// which half was asked for.

	// fill port, {line, beat} addressing.
	always_ff @(posedge fsabi_clk) begin
		if (wr_en) begin
			mem_hi[{wr_idx, wr_dword}] <= wr_data[63:32];
			mem_lo[{wr_idx, wr_dword}] <= wr_data[31:0];
		end
	end

	// core port, one cycle of latency.
	always_ff @(posedge clk) begin
		hi_q   <= mem_hi[{rd_addr.f.idx, rd_addr.f.dword}];
		lo_q   <= mem_lo[{rd_addr.f.idx, rd_addr.f.dword}];
		half_q <= rd_addr.f.half;
	end

	assign rd_data = half_q ? hi_q : lo_q;

endmodule

// File: hdl/icache_fill.sv
/* Fill engine of the instruction cache, on fsabi_clk.
 * Picks up a new fill from the core's read toggle, counts the eight beats
 * addressed to this cache into the data store and hands the toggle back
 * once the last beat is written.
 */

module icache_fill
	import fsab_pkg::*;
(
	input  logic          fsabi_clk,
	input  logic          fsabi_rst_b,
	input  fsab_resp_t    fsabi,	// inbound beats, any device.
	input  logic          cur_read,	// clk domain, toggles per fill.
	output logic          wr_en,	// write one beat this cycle.
	output icache_dword_t wr_dword,	// beat position within the line.
	output logic [63:0]   wr_data,
	output logic          done_read	// set equal to cur_read when done.
);

	logic          cur_s1;	// first synchronizer stage.
	logic          cur_sync;	// read toggle, now on fsabi_clk.
	logic          cur_last;	// cur_sync one cycle back.
	logic          new_fill;
	logic          beat_match;
	icache_dword_t beat;	// next beat to write.

	////////////////////////////////////////////////////////////////////////////
	// read toggle synchronizer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			cur_s1   <= 1'b0;
			cur_sync <= 1'b0;
			cur_last <= 1'b0;
		end else begin
			cur_s1   <= cur_read;
			cur_sync <= cur_s1;
			cur_last <= cur_sync;
		end
	end

	assign new_fill = cur_sync ^ cur_last;	// edge of the toggle.

	// beats for other devices share the bus and are dropped here.
	assign beat_match = fsabi.valid && (fsabi.did == FSAB_DID_CPU) &&
	                    (fsabi.subdid == FSAB_SUBDID_CPU_ICACHE);

	////////////////////////////////////////////////////////////////////////////
	// beat counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			beat      <= '0;
			done_read <= 1'b0;
		end else if (new_fill) begin
			beat <= '0;	// rewind for the new line.
		end else if (beat_match) begin
			beat <= beat + 1'b1;	// wraps to 0 after the last beat.
			if (beat == icache_dword_t'(ICACHE_DWORDS - 1)) begin
				done_read <= cur_sync;	// whole line is in the store.
			end
		end
	end

	assign wr_en    = beat_match && !new_fill;
	assign wr_dword = beat;
	assign wr_data  = fsabi.data;

endmodule

// File: hdl/icache_tag_ctl.sv
/* Core-side control of the instruction cache, on clk.
 * Holds the tag and valid store, computes hit and the wait level, starts a
 * line fill on a miss and commits the line once the fill engine hands back
 * its completion toggle.
 */

module icache_tag_ctl
	import fsab_pkg::*;
(
	input  logic         clk,
	input  logic         rst_b,
	input  icache_addr_u rd_addr,	// core fetch address.
	input  logic         rd_req,
	input  logic         credit_avail,	// from the bus request side.
	input  logic         done_read,	// fsabi_clk domain, toggles per fill.
	output logic         rd_wait,
	output logic         miss_start,
	output icache_addr_u fill_addr,	// line base of the pending fill.
	output logic         cur_read	// toggles once per started fill.
);

	logic [ICACHE_LINES-1:0] line_valid;
	icache_tag_t             tag_mem [ICACHE_LINES];	// one tag per line.

	logic fill_pending;	// a fill is on its way.
	logic done_s1;	// first synchronizer stage.
	logic done_sync;	// completion toggle, now on clk.
	logic hit;
	logic fill_done;

	////////////////////////////////////////////////////////////////////////////
	// hit and wait
	////////////////////////////////////////////////////////////////////////////

	assign hit = line_valid[rd_addr.f.idx] && (tag_mem[rd_addr.f.idx] == rd_addr.f.tag);

	assign rd_wait = rd_req && !hit;	// level, held until the line is in.

	// one fill at a time; without a credit the core just keeps waiting.
	assign miss_start = rd_wait && !fill_pending && credit_avail;

	// the two toggles agree again once the fill engine has seen beat 7.
	assign fill_done = fill_pending && (done_sync == cur_read);

	////////////////////////////////////////////////////////////////////////////
	// completion toggle synchronizer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			done_s1   <= 1'b0;
			done_sync <= 1'b0;
		end else begin
			done_s1   <= done_read;	// crosses from fsabi_clk.
			done_sync <= done_s1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// fill state and valid bits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			line_valid   <= '0;	// cold cache.
			fill_pending <= 1'b0;
			cur_read     <= 1'b0;
		end else if (miss_start) begin
			fill_pending                <= 1'b1;
			cur_read                    <= ~cur_read;	// tells the fill engine to rewind.
			line_valid[rd_addr.f.idx]   <= 1'b0;	// line is being overwritten.
		end else if (fill_done) begin
			fill_pending                <= 1'b0;
			line_valid[fill_addr.f.idx] <= 1'b1;
		end
	end

	// fill_addr stays frozen while pending, so the fill engine reads it
	// across the domain boundary without a synchronizer.
	always_ff @(posedge clk) begin
		if (miss_start) begin
			fill_addr.word <= {rd_addr.word[31:6], 6'b0};	// line base.
		end
	end

	always_ff @(posedge clk) begin
		if (fill_done) begin
			tag_mem[fill_addr.f.idx] <= fill_addr.f.tag;	// same cycle as the valid bit.
		end
	end

endmodule

// File: hdl/fsab_req.sv
/* Outbound side of the cache on the FSAB bus.
 * Tracks the bus credits and drives a line-read request in the cycle that
 * the tag controller starts a miss.
 */

module fsab_req
	import fsab_pkg::*;
#(
	parameter int FSAB_CREDITS = 4	// credits granted at reset.
) (
	input  logic        clk,
	input  logic        rst_b,
	input  logic        miss_start,	// one-cycle start of a line fill.
	input  logic [31:0] fill_base,	// line base of the missing address.
	input  logic        fsabo_credit,	// one credit returned.
	output logic        credit_avail,	// at least one credit left.
	output fsab_req_t   fsabo
);

	fsab_credit_t credits;	// credits currently held.

	////////////////////////////////////////////////////////////////////////////
	// credit counter
	////////////////////////////////////////////////////////////////////////////

	// every request is exactly one cycle, so one valid costs one credit.
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= fsab_credit_t'(FSAB_CREDITS);
		end else begin
			case ({fsabo_credit, miss_start})
				2'b10:   credits <= credits + 1'b1;	// return only.
				2'b01:   credits <= credits - 1'b1;	// issue only.
				default: credits <= credits;	// none, or both cancel.
			endcase
		end
	end

	assign credit_avail = (credits != '0);	// zero credits holds the miss off.

	////////////////////////////////////////////////////////////////////////////
	// request
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		fsabo        = '0;
		fsabo.valid  = miss_start;	// only ever a read from here.
		fsabo.mode   = FSAB_READ;
		fsabo.did    = FSAB_DID_CPU;
		fsabo.subdid = FSAB_SUBDID_CPU_ICACHE;	// beats come back tagged with this.
		fsabo.addr   = fill_base;
		fsabo.len    = FSAB_LINE_LEN;	// whole line, 8 beats.
		fsabo.data   = '0;
		fsabo.mask   = '0;
	end

endmodule

// File: hdl/fsab_pkg.sv
/* Shared definitions for the FSAB memory bus and the instruction cache.
 * Bus request and response beats travel as packed structs; the cache read
 * address is one packed union, seen either as a flat word or as cache fields.
 * Every RTL file and the bench import this package.
 */

package fsab_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		FSAB_READ  = 3'b000,	// burst read, len beats come back.
		FSAB_WRITE = 3'b001	// write, data and mask carry the payload.
	} fsab_mode_t;

	localparam logic [3:0] FSAB_DID_CPU           = 4'h0;	// the core complex.
	localparam logic [3:0] FSAB_SUBDID_CPU_ICACHE = 4'h1;	// this cache within it.

	localparam int FSAB_CREDIT_W = 3;	// enough for up to 7 outstanding.

	typedef logic [FSAB_CREDIT_W-1:0] fsab_credit_t;

	// outbound request, one cycle per request.
	typedef struct packed {
		logic        valid;	// request present this cycle.
		fsab_mode_t  mode;
		logic [3:0]  did;	// requester device id.
		logic [3:0]  subdid;	// requester sub-device id.
		logic [31:0] addr;	// byte address, 8-byte aligned.
		logic [3:0]  len;	// number of 64-bit beats.
		logic [63:0] data;	// write data, zero on reads.
		logic [7:0]  mask;	// write byte mask, zero on reads.
	} fsab_req_t;

	// inbound beat, routed back by did and subdid.
	typedef struct packed {
		logic        valid;
		logic [3:0]  did;
		logic [3:0]  subdid;
		logic [63:0] data;	// high word is the higher address.
	} fsab_resp_t;

	////////////////////////////////////////////////////////////////////////////
	// cache geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int         ICACHE_LINES  = 16;	// direct mapped.
	localparam int         ICACHE_DWORDS = 8;	// 64-bit beats per 64-byte line.
	localparam logic [3:0] FSAB_LINE_LEN = 4'd8;	// len of one line read.

	typedef logic [21:0] icache_tag_t;
	typedef logic [3:0]  icache_idx_t;
	typedef logic [2:0]  icache_dword_t;

	typedef struct packed {
		icache_tag_t   tag;	// bits 31:10.
		icache_idx_t   idx;	// bits 9:6, picks the line.
		icache_dword_t dword;	// bits 5:3, picks the beat.
		logic          half;	// bit 2, hi or lo word of the beat.
		logic [1:0]    boff;	// byte offset, ignored.
	} icache_fields_t;

	typedef union packed {
		logic [31:0]    word;
		icache_fields_t f;
	} icache_addr_u;

endpackage
